//--- build.f
verilog/mem_types_pkg.sv
verilog/fillq_pkg.sv
verilog/fillq_entry.sv
verilog/fillq_alloc.sv
verilog/fillq_mem_arb.sv
verilog/fillq_fill_pipe.sv
verilog/fillq_top.sv
sim/wb_mem_model.sv
sim/fillq_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module fillq_tb -f build.f -o fillq_sim
	./obj_dir/fillq_sim > sim.log 2>&1; cat sim.log
	@if grep -q "Checks failed" sim.log; then exit 1; fi
	@grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/fillq_tb.sv
`timescale 1ns/10ps

module fillq_tb;
    import mem_types_pkg::*;

    localparam int          CLK_PERIOD      = 10;
    localparam int          RESET_CYCLES    = 16;
    localparam int          RAND_MISSES     = 12;
    // Random run, merge pair, full queue, back-pressure
    localparam int          TOTAL_MISSES    = RAND_MISSES + 2 + 5 + 4;
    localparam int          CYCLES_PER_MISS = 200;
    localparam logic [31:0] SEED            = 32'd22776;

    logic               clk;
    logic               reset;
    logic               miss_valid;
    logic [PADDR_W-1:0] miss_addr;
    logic               miss_ready;
    t_wb_m2s            wb_m2s;
    t_wb_s2m            wb_s2m;
    logic               fill_ready;
    logic               fill_valid;
    logic [PADDR_W-1:0] fill_addr;
    logic [LINE_W-1:0]  fill_data;

    // Lines in flight by address, holding the expected fill data
    logic [LINE_W-1:0]  pending [logic [PADDR_W-1:0]];
    int                 errors;
    int                 wb_errors;
    int                 failed_tests;
    int                 fill_total;
    int                 ack_total;
    logic               idle_check;
    string              cur_test;
    logic [31:0]        rng;

    fillq_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .miss_valid (miss_valid),
        .miss_addr  (miss_addr),
        .miss_ready (miss_ready),
        .wb_m2s     (wb_m2s),
        .wb_s2m     (wb_s2m),
        .fill_ready (fill_ready),
        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .fill_data  (fill_data)
    );

    wb_mem_model mem_i (
        .clk    (clk),
        .reset  (reset),
        .wb_m2s (wb_m2s),
        .wb_s2m (wb_s2m)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [LINE_W-1:0] line_pattern(input logic [PADDR_W-1:0] addr);
        return {addr, ~addr};
    endfunction

    a_idle_after_reset: assert property (@(posedge clk) disable iff (reset)
        idle_check |-> !fill_valid && !wb_m2s.cyc && !wb_m2s.stb && miss_ready)
        else begin
            errors++;
            $display("after reset a fill or bus cycle started, or miss_ready was low");
        end

    a_no_fill_held: assert property (@(posedge clk) disable iff (reset)
        !fill_ready |-> !fill_valid)
        else begin
            errors++;
            $display("fill_valid high while fill_ready was low");
        end

    a_wb_hold: assert property (@(posedge clk) disable iff (reset)
        wb_m2s.stb && !wb_s2m.ack |=> wb_m2s.stb && $stable(wb_m2s.adr))
        else begin
            errors++;
            wb_errors++;
            $display("wishbone stb dropped or adr moved before ack");
        end

    a_wb_read_only: assert property (@(posedge clk) disable iff (reset)
        !wb_m2s.we && (wb_m2s.cyc == wb_m2s.stb))
        else begin
            errors++;
            wb_errors++;
            $display("wishbone we high, or cyc and stb differ");
        end

    // A miss to a line in flight merges even on its fill cycle
    always @(posedge clk) begin
        if (!reset) begin
            if (wb_m2s.stb && wb_s2m.ack) begin
                ack_total++;
            end
            if (miss_valid && miss_ready && !pending.exists(miss_addr)) begin
                pending[miss_addr] = line_pattern(miss_addr);
            end
            if (fill_valid) begin
                fill_total++;
                assert (pending.exists(fill_addr)) else begin
                    errors++;
                    $display("fill for address %h in %s was not expected", fill_addr, cur_test);
                end
                if (pending.exists(fill_addr)) begin
                    assert (fill_data == pending[fill_addr]) else begin
                        errors++;
                        $display("ERR %s expected %h actual %h",
                                 cur_test, pending[fill_addr], fill_data);
                    end
                    pending.delete(fill_addr);
                end
            end
        end
    end

    // Starts and ends on a falling edge
    task automatic send_miss(input logic [PADDR_W-1:0] addr);
        miss_valid = 1'b1;
        miss_addr  = addr;
        @(posedge clk);
        while (!miss_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        miss_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (pending.num() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic end_test(input string name, input int errs);
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: FAIL with %0d errors", name, errs);
        end
    endtask

    initial begin
        int errs_at;
        int acks_at;
        int fills_at;
        int merges_at;
        clk          = 1'b0;
        reset        = 1'b1;
        miss_valid   = 1'b0;
        miss_addr    = '0;
        fill_ready   = 1'b1;
        errors       = 0;
        wb_errors    = 0;
        failed_tests = 0;
        fill_total   = 0;
        ack_total    = 0;
        idle_check   = 1'b1;
        rng          = SEED;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        cur_test = "reset_idle";
        errs_at  = errors;
        repeat (10) @(negedge clk);
        idle_check = 1'b0;
        end_test(cur_test, errors - errs_at);

        cur_test = "random_fill";
        errs_at  = errors;
        for (int i = 0; i < RAND_MISSES; i++) begin
            rng = xorshift32(rng);
            send_miss(rng);
        end
        wait_drained();
        end_test(cur_test, errors - errs_at);

        cur_test  = "merge";
        errs_at   = errors;
        acks_at   = ack_total;
        fills_at  = fill_total;
        merges_at = int'(dut_i.alloc_i.merge_cnt);
        send_miss(32'h0000_4a40);
        send_miss(32'h0000_4a40);
        wait_drained();
        repeat (40) @(negedge clk);
        assert (ack_total - acks_at == 1) else begin
            errors++;
            $display("ERR %s expected %0d actual %0d", cur_test, 1, ack_total - acks_at);
        end
        assert (fill_total - fills_at == 1) else begin
            errors++;
            $display("ERR %s expected %0d actual %0d", cur_test, 1, fill_total - fills_at);
        end
        assert (int'(dut_i.alloc_i.merge_cnt) - merges_at == 1) else begin
            errors++;
            $display("ERR %s expected %0d actual %0d", cur_test, 1,
                     int'(dut_i.alloc_i.merge_cnt) - merges_at);
        end
        end_test(cur_test, errors - errs_at);

        cur_test = "full_queue";
        errs_at  = errors;
        fills_at = fill_total;
        for (int i = 0; i < 4; i++) begin
            send_miss(32'h0001_0000 + 32'(i) * 32'h40);
        end
        miss_valid = 1'b1;
        miss_addr  = 32'h0001_0100;
        @(posedge clk);
        assert (!miss_ready) else begin
            errors++;
            $display("miss_ready stayed high with four entries live");
        end
        while (!miss_ready) begin
            @(posedge clk);
        end
        assert (fill_total > fills_at) else begin
            errors++;
            $display("fifth miss accepted before any fill completed");
        end
        @(negedge clk);
        miss_valid = 1'b0;
        wait_drained();
        end_test(cur_test, errors - errs_at);

        cur_test   = "back_pressure";
        errs_at    = errors;
        acks_at    = ack_total;
        fills_at   = fill_total;
        fill_ready = 1'b0;
        for (int i = 0; i < 4; i++) begin
            send_miss(32'h0002_0000 + 32'(i) * 32'h40);
        end
        while (ack_total - acks_at < 4) begin
            @(negedge clk);
        end
        // Let the entries recycle through the pipe a few times
        repeat (30) @(negedge clk);
        assert (fill_total == fills_at && pending.num() == 4) else begin
            errors++;
            $display("lines were delivered while fill_ready was held low");
        end
        fill_ready = 1'b1;
        wait_drained();
        assert (fill_total - fills_at == 4) else begin
            errors++;
            $display("ERR %s expected %0d actual %0d", cur_test, 4, fill_total - fills_at);
        end
        end_test(cur_test, errors - errs_at);

        end_test("wb_protocol", wb_errors);

        $display("tests %0d, failing tests %0d, errors %0d", 6, failed_tests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + CYCLES_PER_MISS * TOTAL_MISSES));
        $display("watchdog expired before all %0d misses were filled", TOTAL_MISSES);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- sim/wb_mem_model.sv
`timescale 1ns/10ps

module wb_mem_model (
    input  logic                   clk,
    input  logic                   reset,
    input  mem_types_pkg::t_wb_m2s wb_m2s,
    output mem_types_pkg::t_wb_s2m wb_s2m
);
    localparam logic [31:0] SEED = 32'd22776;

    logic [31:0] rng;
    logic        active;
    logic        ack;
    logic [1:0]  wait_cnt;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Wait states drawn once per bus cycle, 0 to 3
    always_ff @(posedge clk) begin
        if (reset) begin
            rng      <= SEED;
            active   <= 1'b0;
            ack      <= 1'b0;
            wait_cnt <= '0;
        end else if (ack) begin
            ack <= 1'b0;
        end else if (wb_m2s.cyc && wb_m2s.stb) begin
            if (!active) begin
                active   <= 1'b1;
                wait_cnt <= rng[1:0];
                rng      <= xorshift32(rng);
            end else if (wait_cnt == 2'd0) begin
                active <= 1'b0;
                ack    <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    assign wb_s2m.ack = ack;
    // Line data is the address followed by its inversion
    assign wb_s2m.dat = {wb_m2s.adr, ~wb_m2s.adr};

endmodule

//--- verilog/fillq_top.sv
`timescale 1ns/10ps

module fillq_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              miss_valid,
    input  logic [mem_types_pkg::PADDR_W-1:0] miss_addr,
    output logic                              miss_ready,
    output mem_types_pkg::t_wb_m2s            wb_m2s,
    input  mem_types_pkg::t_wb_s2m            wb_s2m,
    input  logic                              fill_ready,
    output logic                              fill_valid,
    output logic [mem_types_pkg::PADDR_W-1:0] fill_addr,
    output logic [mem_types_pkg::LINE_W-1:0]  fill_data
);
    import mem_types_pkg::*;
    import fillq_pkg::*;

    logic [FLQ_ENTRIES-1:0]                 e_valid;
    t_flq_static [FLQ_ENTRIES-1:0]          e_static;
    logic [FLQ_ENTRIES-1:0]                 alloc;
    t_flq_static                            alloc_static;
    logic [FLQ_ENTRIES-1:0]                 mem_req;
    t_mem_req_pkt [FLQ_ENTRIES-1:0]         mem_req_pkt;
    logic [FLQ_ENTRIES-1:0]                 mem_gnt;
    t_mem_rsp_pkt                           mem_rsp_pkt;
    logic [FLQ_ENTRIES-1:0]                 pipe_req;
    t_fill_pipe_req [FLQ_ENTRIES-1:0]       pipe_req_pkt;
    logic [FLQ_ENTRIES-1:0]                 pipe_gnt;
    logic                                   pipe_valid_mm5;
    t_fill_pipe_req                         pipe_pkt_mm5;
    t_fill_pipe_action                      pipe_action_mm5;

    fillq_alloc alloc_i (
        .clk          (clk),
        .reset        (reset),
        .miss_valid   (miss_valid),
        .miss_addr    (miss_addr),
        .miss_ready   (miss_ready),
        .e_valid      (e_valid),
        .e_static     (e_static),
        .alloc        (alloc),
        .alloc_static (alloc_static)
    );

    for (genvar i = 0; i < FLQ_ENTRIES; i++) begin : g_entry
        fillq_entry entry_i (
            .clk             (clk),
            .reset           (reset),
            .id              (t_flq_id'(i)),
            .alloc           (alloc[i]),
            .alloc_static    (alloc_static),
            .e_valid         (e_valid[i]),
            .e_static        (e_static[i]),
            .mem_req         (mem_req[i]),
            .mem_req_pkt     (mem_req_pkt[i]),
            .mem_gnt         (mem_gnt[i]),
            .mem_rsp_pkt     (mem_rsp_pkt),
            .pipe_req        (pipe_req[i]),
            .pipe_req_pkt    (pipe_req_pkt[i]),
            .pipe_gnt        (pipe_gnt[i]),
            .pipe_valid_mm5  (pipe_valid_mm5),
            .pipe_pkt_mm5    (pipe_pkt_mm5),
            .pipe_action_mm5 (pipe_action_mm5)
        );
    end

    fillq_mem_arb mem_arb_i (
        .clk         (clk),
        .reset       (reset),
        .mem_req     (mem_req),
        .mem_req_pkt (mem_req_pkt),
        .mem_gnt     (mem_gnt),
        .mem_rsp_pkt (mem_rsp_pkt),
        .wb_m2s      (wb_m2s),
        .wb_s2m      (wb_s2m)
    );

    fillq_fill_pipe fill_pipe_i (
        .clk             (clk),
        .reset           (reset),
        .pipe_req        (pipe_req),
        .pipe_req_pkt    (pipe_req_pkt),
        .pipe_gnt        (pipe_gnt),
        .pipe_valid_mm5  (pipe_valid_mm5),
        .pipe_pkt_mm5    (pipe_pkt_mm5),
        .pipe_action_mm5 (pipe_action_mm5),
        .fill_ready      (fill_ready),
        .fill_valid      (fill_valid),
        .fill_addr       (fill_addr),
        .fill_data       (fill_data)
    );

endmodule

//--- verilog/fillq_fill_pipe.sv
`timescale 1ns/10ps

module fillq_fill_pipe (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  logic [fillq_pkg::FLQ_ENTRIES-1:0]                      pipe_req,
    input  fillq_pkg::t_fill_pipe_req [fillq_pkg::FLQ_ENTRIES-1:0] pipe_req_pkt,
    output logic [fillq_pkg::FLQ_ENTRIES-1:0]                      pipe_gnt,
    output logic                                                   pipe_valid_mm5,
    output fillq_pkg::t_fill_pipe_req                              pipe_pkt_mm5,
    output fillq_pkg::t_fill_pipe_action                           pipe_action_mm5,
    input  logic                                                   fill_ready,
    output logic                                                   fill_valid,
    output logic [mem_types_pkg::PADDR_W-1:0]                      fill_addr,
    output logic [mem_types_pkg::LINE_W-1:0]                       fill_data
);
    import fillq_pkg::*;

    t_flq_id                rr_ptr;
    t_flq_id                pick_id;
    logic                   valid_mm0;
    t_fill_pipe_req         pkt_mm0;
    logic [FILL_MM_LAST:1]  valid_q;
    t_fill_pipe_req         pkt_q [FILL_MM_LAST:1];
    logic [FLQ_ENTRIES-1:0] in_flight;

    // mm0 is the grant cycle
    assign pick_id   = rr_pick(pipe_req, rr_ptr);
    assign valid_mm0 = |pipe_req;
    assign pkt_mm0   = pipe_req_pkt[pick_id];

    always_comb begin
        pipe_gnt          = '0;
        pipe_gnt[pick_id] = valid_mm0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            rr_ptr  <= '0;
        end else begin
            valid_q <= {valid_q[FILL_MM_LAST-1:1], valid_mm0};
            if (valid_mm0) begin
                rr_ptr <= pick_id + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        pkt_q[1] <= pkt_mm0;
        for (int s = 2; s <= FILL_MM_LAST; s++) begin
            pkt_q[s] <= pkt_q[s-1];
        end
    end

    assign pipe_valid_mm5 = valid_q[FILL_MM_LAST];
    assign pipe_pkt_mm5   = pkt_q[FILL_MM_LAST];

    // Cache side back-pressure turns the fill into a recycle
    assign pipe_action_mm5.complete = pipe_valid_mm5 && fill_ready;
    assign pipe_action_mm5.recycle  = pipe_valid_mm5 && !fill_ready;

    assign fill_valid = pipe_action_mm5.complete;
    assign fill_addr  = pipe_pkt_mm5.addr;
    assign fill_data  = pipe_pkt_mm5.data;

    // Entries occupying mm1 through mm5
    always_comb begin
        in_flight = '0;
        for (int s = 1; s <= FILL_MM_LAST; s++) begin
            if (valid_q[s]) begin
                in_flight[pkt_q[s].id] = 1'b1;
            end
        end
    end

    a_one_slot: assert property (@(posedge clk) disable iff (reset)
        (pipe_gnt & in_flight) == '0)
        else $error("fill pipe granted an entry that is already in flight");

endmodule

//--- verilog/fillq_mem_arb.sv
`timescale 1ns/10ps

module fillq_mem_arb (
    input  logic                                                      clk,
    input  logic                                                      reset,
    input  logic [fillq_pkg::FLQ_ENTRIES-1:0]                         mem_req,
    input  mem_types_pkg::t_mem_req_pkt [fillq_pkg::FLQ_ENTRIES-1:0]  mem_req_pkt,
    output logic [fillq_pkg::FLQ_ENTRIES-1:0]                         mem_gnt,
    output mem_types_pkg::t_mem_rsp_pkt                               mem_rsp_pkt,
    output mem_types_pkg::t_wb_m2s                                    wb_m2s,
    input  mem_types_pkg::t_wb_s2m                                    wb_s2m
);
    import mem_types_pkg::*;
    import fillq_pkg::*;

    t_flq_id            rr_ptr;
    t_flq_id            pick_id;
    logic               grant;
    logic               bus_busy;
    logic               bus_ack;
    t_flq_id            cur_id;
    logic [PADDR_W-1:0] cur_adr;
    logic               rsp_valid;
    t_flq_id            rsp_id;
    logic [LINE_W-1:0]  rsp_data;

    assign pick_id = rr_pick(mem_req, rr_ptr);
    // New bus cycle only once the previous one has fully dropped
    assign grant   = !bus_busy && (|mem_req);
    assign bus_ack = bus_busy && wb_s2m.ack;

    always_comb begin
        mem_gnt          = '0;
        mem_gnt[pick_id] = grant;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_busy  <= 1'b0;
            rr_ptr    <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= bus_ack;
            if (grant) begin
                bus_busy <= 1'b1;
                rr_ptr   <= pick_id + 1'b1;
            end else if (bus_ack) begin
                bus_busy <= 1'b0;
            end
        end
    end

    // Id and address held through the bus cycle
    always_ff @(posedge clk) begin
        if (grant) begin
            cur_id  <= pick_id;
            cur_adr <= mem_req_pkt[pick_id].addr;
        end
        if (bus_ack) begin
            rsp_id   <= cur_id;
            rsp_data <= wb_s2m.dat;
        end
    end

    always_comb begin
        wb_m2s.cyc = bus_busy;
        wb_m2s.stb = bus_busy;
        wb_m2s.we  = 1'b0;
        wb_m2s.adr = cur_adr;
        wb_m2s.dat = '0;
    end

    assign mem_rsp_pkt.valid = rsp_valid;
    assign mem_rsp_pkt.id    = rsp_id;
    assign mem_rsp_pkt.data  = rsp_data;

    a_wb_hold: assert property (@(posedge clk) disable iff (reset)
        wb_m2s.stb && !wb_s2m.ack |=> wb_m2s.stb && $stable(wb_m2s.adr))
        else $error("wishbone stb or adr changed before ack");

endmodule

//--- verilog/fillq_alloc.sv
`timescale 1ns/10ps

module fillq_alloc (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                miss_valid,
    input  logic [mem_types_pkg::PADDR_W-1:0]                   miss_addr,
    output logic                                                miss_ready,
    input  logic [fillq_pkg::FLQ_ENTRIES-1:0]                   e_valid,
    input  fillq_pkg::t_flq_static [fillq_pkg::FLQ_ENTRIES-1:0] e_static,
    output logic [fillq_pkg::FLQ_ENTRIES-1:0]                   alloc,
    output fillq_pkg::t_flq_static                              alloc_static
);
    import fillq_pkg::*;

    logic [FLQ_ENTRIES-1:0] line_hit;
    logic [FLQ_ENTRIES-1:0] free;
    logic [FLQ_ENTRIES-1:0] first_free;
    logic                   merge;
    logic [MERGE_CNT_W-1:0] merge_cnt;
    logic                   dup_line;

    always_comb begin
        for (int i = 0; i < FLQ_ENTRIES; i++) begin
            line_hit[i] = e_valid[i] && (e_static[i].paddr == miss_addr);
        end
    end

    assign free       = ~e_valid;
    // Isolate the lowest set bit
    assign first_free = free & (~free + 1'b1);

    assign merge      = miss_valid && (|line_hit);
    assign miss_ready = (|line_hit) || (|free);

    assign alloc              = (miss_valid && !merge) ? first_free : '0;
    assign alloc_static.paddr = miss_addr;

    // Saturating count of merged misses for debug
    always_ff @(posedge clk) begin
        if (reset) begin
            merge_cnt <= '0;
        end else if (merge && (merge_cnt != '1)) begin
            merge_cnt <= merge_cnt + 1'b1;
        end
    end

    always_comb begin
        dup_line = 1'b0;
        for (int i = 0; i < FLQ_ENTRIES; i++) begin
            for (int j = i + 1; j < FLQ_ENTRIES; j++) begin
                if (e_valid[i] && e_valid[j] && (e_static[i].paddr == e_static[j].paddr)) begin
                    dup_line = 1'b1;
                end
            end
        end
    end

    // Merging keeps every live line in one entry only
    a_line_unique: assert property (@(posedge clk) disable iff (reset) !dup_line)
        else $error("two live fill queue entries hold the same line");

endmodule

//--- verilog/fillq_entry.sv
`timescale 1ns/10ps

module fillq_entry (
    input  logic                         clk,
    input  logic                         reset,
    input  fillq_pkg::t_flq_id           id,
    input  logic                         alloc,
    input  fillq_pkg::t_flq_static       alloc_static,
    output logic                         e_valid,
    output fillq_pkg::t_flq_static       e_static,
    output logic                         mem_req,
    output mem_types_pkg::t_mem_req_pkt  mem_req_pkt,
    input  logic                         mem_gnt,
    input  mem_types_pkg::t_mem_rsp_pkt  mem_rsp_pkt,
    output logic                         pipe_req,
    output fillq_pkg::t_fill_pipe_req    pipe_req_pkt,
    input  logic                         pipe_gnt,
    input  logic                         pipe_valid_mm5,
    input  fillq_pkg::t_fill_pipe_req    pipe_pkt_mm5,
    input  fillq_pkg::t_fill_pipe_action pipe_action_mm5
);
    import mem_types_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQ_MEM,
        ST_WAIT_MEM,
        ST_REQ_PIPE,
        ST_WAIT_PIPE,
        ST_WAIT
    } t_state;

    t_state            state;
    t_state            state_nxt;
    logic              rsp_hit;
    logic              mm5_hit;
    logic [LINE_W-1:0] line_data;

    assign rsp_hit = mem_rsp_pkt.valid && (mem_rsp_pkt.id == id);
    assign mm5_hit = pipe_valid_mm5 && (pipe_pkt_mm5.id == id);

    always_comb begin
        state_nxt = state;
        unique case (state)
            ST_IDLE:      if (alloc) state_nxt = ST_REQ_MEM;
            ST_REQ_MEM:   if (mem_gnt) state_nxt = ST_WAIT_MEM;
            ST_WAIT_MEM:  if (rsp_hit) state_nxt = ST_REQ_PIPE;
            ST_REQ_PIPE:  if (pipe_gnt) state_nxt = ST_WAIT_PIPE;
            ST_WAIT_PIPE: begin
                if (mm5_hit && pipe_action_mm5.complete) begin
                    state_nxt = ST_IDLE;
                end else if (mm5_hit && pipe_action_mm5.recycle) begin
                    state_nxt = ST_WAIT;
                end
            end
            // Back off one cycle before asking the pipe again
            ST_WAIT:      state_nxt = ST_REQ_PIPE;
            default:      state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            e_static <= alloc_static;
        end
        if (rsp_hit) begin
            line_data <= mem_rsp_pkt.data;
        end
    end

    assign e_valid  = (state != ST_IDLE);
    assign mem_req  = (state == ST_REQ_MEM);
    assign pipe_req = (state == ST_REQ_PIPE);

    assign mem_req_pkt.valid = mem_req;
    assign mem_req_pkt.id    = id;
    assign mem_req_pkt.addr  = e_static.paddr;

    assign pipe_req_pkt.id   = id;
    assign pipe_req_pkt.addr = e_static.paddr;
    assign pipe_req_pkt.data = line_data;

    a_alloc_idle: assert property (@(posedge clk) disable iff (reset) alloc |-> !e_valid)
        else $error("fill queue entry %0d allocated while live", id);

    // A tagged response only ever lands on an entry that is waiting for it
    a_rsp_expected: assert property (@(posedge clk) disable iff (reset)
        rsp_hit |-> state == ST_WAIT_MEM)
        else $error("fill queue entry %0d got an unexpected response", id);

endmodule

//--- verilog/fillq_pkg.sv
package fillq_pkg;

    localparam int FLQ_ENTRIES  = 4;
    localparam int FLQ_ID_W     = $clog2(FLQ_ENTRIES);
    // Fill pipe runs mm0 through mm5
    localparam int FILL_MM_LAST = 5;
    localparam int MERGE_CNT_W  = 16;

    typedef logic [FLQ_ID_W-1:0] t_flq_id;

    typedef struct packed {
        logic [mem_types_pkg::PADDR_W-1:0] paddr;
    } t_flq_static;

    typedef struct packed {
        t_flq_id                          id;
        logic [mem_types_pkg::PADDR_W-1:0] addr;
        logic [mem_types_pkg::LINE_W-1:0]  data;
    } t_fill_pipe_req;

    typedef struct packed {
        logic complete;
        logic recycle;
    } t_fill_pipe_action;

    // Rotating priority, ptr has the highest priority
    // Entry count is a power of two so the index wraps on its own
    function automatic t_flq_id rr_pick(
        input logic [FLQ_ENTRIES-1:0] req,
        input t_flq_id                ptr
    );
        t_flq_id pick;
        t_flq_id idx;
        pick = ptr;
        for (int i = FLQ_ENTRIES - 1; i >= 0; i--) begin
            idx = ptr + t_flq_id'(i);
            if (req[idx]) begin
                pick = idx;
            end
        end
        return pick;
    endfunction

endpackage

//--- verilog/mem_types_pkg.sv
package mem_types_pkg;

    localparam int PADDR_W  = 32;
    localparam int LINE_W   = 64;
    localparam int MEM_ID_W = 2;

    // One line read, tagged with the requesting entry
    typedef struct packed {
        logic                valid;
        logic [MEM_ID_W-1:0] id;
        logic [PADDR_W-1:0]  addr;
    } t_mem_req_pkt;

    typedef struct packed {
        logic                valid;
        logic [MEM_ID_W-1:0] id;
        logic [LINE_W-1:0]   data;
    } t_mem_rsp_pkt;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [PADDR_W-1:0] adr;
        logic [LINE_W-1:0]  dat;
    } t_wb_m2s;

    typedef struct packed {
        logic              ack;
        logic [LINE_W-1:0] dat;
    } t_wb_s2m;

endpackage
